//--- verilog.f
ahb_pkg.sv
crc_pkg.sv
crc_cfg_if.sv
crc_host_interface.sv
crc_input_buffer.sv
crc_ctrl_fsm.sv
crc_byte_counter.sv
crc_datapath.sv
crc_ahb_top.sv
tb_crc_ahb.sv

//--- Bender.yml
package:
  name: crc_ahb

sources:
  - ahb_pkg.sv
  - crc_pkg.sv
  - crc_cfg_if.sv
  - crc_host_interface.sv
  - crc_input_buffer.sv
  - crc_ctrl_fsm.sv
  - crc_byte_counter.sv
  - crc_datapath.sv
  - crc_ahb_top.sv
  - target: simulation
    files:
      - tb_crc_ahb.sv

//--- tb_crc_ahb.sv
module tb_crc_ahb
	import ahb_pkg::*, crc_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// One row of the stimulus table
	typedef struct packed
	{
		logic        write;
		crc_reg_t    r;
		hsize_t      size;
		logic [31:0] data;
		logic [31:0] expected;
		logic        rand_data;
		logic        use_model;
		logic [3:0]  test;
	} step_t;

	// DUT ports
	logic        HCLK;
	logic        HRESETn;
	logic        HSELx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic        HREADY;
	logic [31:0] HWDATA;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	step_t       steps [$];
	step_t       cur;
	string       test_names [1:6];
	int          build_test;
	int          cur_test;
	int          errors;
	int          test_errors;
	int          tests_passed;
	int          tests_failed;
	int          reads_checked;
	bit          table_ready;
	logic [31:0] rdata;
	logic [31:0] expected;

	// Reference model state
	logic [31:0] m_crc;
	logic [31:0] m_init;
	logic [31:0] m_poly;
	logic [7:0]  m_idr;
	// {rev_out, rev_in, poly_size}
	logic [4:0]  m_cr;

	crc_ahb_top i_dut (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSELx     (HSELx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HREADY    (HREADY),
		.HWDATA    (HWDATA),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	always #4 HCLK = ~HCLK;

	//////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic int poly_width(input logic [1:0] ps);
		case (poly_size_t'(ps))
			P32:     return 32;
			P16:     return 16;
			P8:      return 8;
			default: return 7;
		endcase
	endfunction

	function automatic logic [31:0] low_mask(input int w);
		if (w >= 32)
			return 32'hFFFF_FFFF;
		return (32'h1 << w) - 1;
	endfunction

	// Mirror bits inside every rw wide chunk of the low xfer_w bits
	function automatic logic [31:0] mirror_chunks(input logic [31:0] d, input int xfer_w,
		input int rw);
		logic [31:0] r;
		r = d;
		for (int c = 0; c < xfer_w; c += rw)
		begin
			for (int j = 0; j < rw; j++)
				r[c + j] = d[c + rw - 1 - j];
		end
		return r;
	endfunction

	// Bytes go high first, bits MSB first, feedback is top bit XOR data bit
	function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [31:0] d,
		input hsize_t size, input logic [4:0] cr, input logic [31:0] poly);
		int          nbytes;
		int          w;
		int          rw;
		logic [31:0] mask;
		logic [31:0] lane;
		logic        fb;
		nbytes = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
		w      = poly_width(cr[1:0]);
		mask   = low_mask(w);
		lane   = d & low_mask(8 * nbytes);
		case (rev_in_t'(cr[3:2]))
			REV_BYTE: rw = 8;
			REV_HALF: rw = 16;
			REV_WORD: rw = 32;
			default:  rw = 0;
		endcase
		if (rw > 8 * nbytes)
			rw = 8 * nbytes;
		if (rw != 0)
			lane = mirror_chunks(lane, 8 * nbytes, rw);
		for (int k = nbytes - 1; k >= 0; k--)
		begin
			for (int b = 7; b >= 0; b--)
			begin
				fb  = crc[w - 1] ^ lane[8 * k + b];
				crc = (crc << 1) & mask;
				if (fb)
					crc = crc ^ (poly & mask);
			end
		end
		return crc;
	endfunction

	function automatic logic [31:0] model_read(input crc_reg_t r);
		logic [31:0] v;
		int          w;
		w = poly_width(m_cr[1:0]);
		case (r)
			DR:
			begin
				v = m_crc & low_mask(w);
				if (m_cr[4])
					v = mirror_chunks(v, w, w);
				return v;
			end
			IDR:     return {24'h0, m_idr};
			CR:      return {24'h0, m_cr, 3'b000};
			INIT:    return m_init;
			POL:     return m_poly;
			default: return 32'h0;
		endcase
	endfunction

	task automatic model_write(input crc_reg_t r, input hsize_t size, input logic [31:0] d);
		case (r)
			DR:   m_crc = crc_update(m_crc, d, size, m_cr, m_poly);
			IDR:  m_idr = d[7:0];
			CR:
			begin
				// Restart seeds from the INIT value held before this write
				if (d[0])
					m_crc = m_init;
				m_cr = d[7:3];
			end
			INIT:
			begin
				m_init = d;
				m_crc  = d;
			end
			POL:  m_poly = d;
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Table construction

	task automatic add_step(input logic wr, input crc_reg_t r, input hsize_t size,
		input logic [31:0] d, input logic [31:0] exp_val, input logic rnd, input logic mdl);
		step_t s;
		s.write     = wr;
		s.r         = r;
		s.size      = size;
		s.data      = d;
		s.expected  = exp_val;
		s.rand_data = rnd;
		s.use_model = mdl;
		s.test      = 4'(build_test);
		steps.push_back(s);
	endtask

	task automatic write_entry(input crc_reg_t r, input hsize_t size, input logic [31:0] d);
		add_step(1'b1, r, size, d, 32'h0, 1'b0, 1'b0);
	endtask

	task automatic random_entry(input hsize_t size);
		add_step(1'b1, DR, size, 32'h0, 32'h0, 1'b1, 1'b0);
	endtask

	task automatic read_literal(input crc_reg_t r, input logic [31:0] exp_val);
		add_step(1'b0, r, WORD, 32'h0, exp_val, 1'b0, 1'b0);
	endtask

	task automatic read_model(input crc_reg_t r);
		add_step(1'b0, r, WORD, 32'h0, 32'h0, 1'b0, 1'b1);
	endtask

	// ASCII 123456789 as two words and a byte
	task automatic check_string();
		write_entry(DR, WORD, 32'h3132_3334);
		write_entry(DR, WORD, 32'h3536_3738);
		write_entry(DR, BYTE, 32'h0000_0039);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus driver

	// Starts and ends 1 ns after a rising edge
	task automatic ahb_transfer(input logic wr, input crc_reg_t r, input hsize_t size,
		input logic [31:0] wdata, output logic [31:0] rd);
		// Address phase
		HSELx  = 1'b1;
		HADDR  = {27'h0, r, 2'b00};
		HTRANS = NONSEQ;
		HSIZE  = size;
		HWRITE = wr;
		@(posedge HCLK);
		#1;
		// Data phase with the bus idle behind it
		HSELx  = 1'b0;
		HTRANS = IDLE;
		HWRITE = 1'b0;
		HWDATA = wr ? wdata : 32'h0;
		#1;
		while (!HREADYOUT)
		begin
			@(posedge HCLK);
			#2;
		end
		rd = HRDATA;
		@(posedge HCLK);
		#1;
	endtask

	task automatic report_test(input int id);
		if (test_errors == 0)
		begin
			$display("PASS   test %0d: %s", id, test_names[id]);
			tests_passed++;
		end
		else
		begin
			$display("FAILED test %0d: %s, %0d errors, at %0t ns", id, test_names[id],
				test_errors, $time);
			tests_failed++;
		end
	endtask

	// Slave must never answer with ERROR
	always @(posedge HCLK)
	begin
		if (HRESETn && HRESP !== OKAY)
		begin
			$display("FAILED at %0t ns: HRESP is not OKAY", $time);
			errors++;
			test_errors++;
		end
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (table_ready);
		#(steps.size() * 20 * 8 + 1000);
		$display("The run timed out after %0t ns with a transfer still pending", $time);
		$display("Some tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		HCLK    = 1'b0;
		HRESETn = 1'b0;
		HSELx   = 1'b0;
		HADDR   = 32'h0;
		HTRANS  = IDLE;
		HSIZE   = WORD;
		HWRITE  = 1'b0;
		HREADY  = 1'b1;
		HWDATA  = 32'h0;
		void'($urandom(32'h01d7_fe99));

		test_names[1] = "reset values";
		test_names[2] = "register access";
		test_names[3] = "CRC-32 word stream";
		test_names[4] = "narrow polynomials";
		test_names[5] = "input and output reversal";
		test_names[6] = "back-pressure and restart";

		build_test = 1;
		read_literal(CR, 32'h0);
		read_literal(IDR, 32'h0);
		read_literal(INIT, 32'hFFFF_FFFF);
		read_literal(POL, 32'h04C1_1DB7);
		read_literal(DR, 32'hFFFF_FFFF);

		build_test = 2;
		write_entry(IDR, WORD, 32'h0000_005A);
		read_literal(IDR, 32'h0000_005A);
		write_entry(IDR, WORD, 32'hDEAD_BEC3);
		read_literal(IDR, 32'h0000_00C3);
		// Restart bit set but reads back zero
		write_entry(CR, WORD, 32'h0000_00FF);
		read_literal(CR, 32'h0000_00F8);
		write_entry(CR, WORD, 32'h0000_0050);
		read_literal(CR, 32'h0000_0050);
		write_entry(INIT, WORD, 32'h1234_5678);
		read_literal(INIT, 32'h1234_5678);
		write_entry(POL, WORD, 32'h0000_1021);
		read_literal(POL, 32'h0000_1021);
		write_entry(POL, WORD, 32'h04C1_1DB7);
		write_entry(INIT, WORD, 32'hFFFF_FFFF);
		write_entry(CR, WORD, 32'h0000_0001);
		read_literal(CR, 32'h0);

		build_test = 3;
		check_string();
		// CRC-32/MPEG-2 check value
		read_literal(DR, 32'h0376_E6E7);
		write_entry(CR, WORD, 32'h0000_0001);
		repeat (4) random_entry(WORD);
		read_model(DR);
		repeat (3) random_entry(WORD);
		read_model(DR);

		build_test = 4;
		// P16 as CRC-16/CCITT-FALSE
		write_entry(CR, WORD, 32'h0000_0009);
		write_entry(POL, WORD, 32'h0000_1021);
		write_entry(INIT, WORD, 32'h0000_FFFF);
		check_string();
		read_literal(DR, 32'h0000_29B1);
		random_entry(BYTE);
		random_entry(HALF);
		random_entry(WORD);
		read_model(DR);
		// Seed wider than the polynomial so the result is masked
		write_entry(INIT, WORD, 32'hFFFF_FFFF);
		random_entry(HALF);
		random_entry(BYTE);
		read_model(DR);
		read_literal(INIT, 32'hFFFF_FFFF);
		// P8
		write_entry(CR, WORD, 32'h0000_0011);
		write_entry(POL, WORD, 32'h0000_0007);
		write_entry(INIT, WORD, 32'h0);
		check_string();
		read_literal(DR, 32'h0000_00F4);
		random_entry(HALF);
		random_entry(BYTE);
		read_model(DR);
		// P7 as CRC-7/MMC
		write_entry(CR, WORD, 32'h0000_0019);
		write_entry(POL, WORD, 32'h0000_0009);
		write_entry(INIT, WORD, 32'h0);
		check_string();
		read_literal(DR, 32'h0000_0075);
		write_entry(INIT, WORD, 32'hFFFF_FFFF);
		random_entry(BYTE);
		random_entry(HALF);
		read_model(DR);

		build_test = 5;
		write_entry(POL, WORD, 32'h04C1_1DB7);
		write_entry(INIT, WORD, 32'hFFFF_FFFF);
		// Reflected CRC-32 before the final inversion
		write_entry(CR, WORD, 32'h0000_00A1);
		check_string();
		read_literal(DR, 32'h340B_C6D9);
		write_entry(CR, WORD, 32'h0000_0021);
		random_entry(WORD);
		random_entry(HALF);
		read_model(DR);
		// Halfword chunks clamp on a byte transfer
		write_entry(CR, WORD, 32'h0000_0041);
		random_entry(BYTE);
		random_entry(WORD);
		read_model(DR);
		write_entry(CR, WORD, 32'h0000_0061);
		random_entry(HALF);
		random_entry(WORD);
		read_model(DR);
		write_entry(CR, WORD, 32'h0000_0089);
		random_entry(HALF);
		read_model(DR);
		write_entry(CR, WORD, 32'h0000_00F9);
		random_entry(WORD);
		read_model(DR);

		build_test = 6;
		write_entry(CR, WORD, 32'h0000_0001);
		repeat (4) random_entry(WORD);
		read_model(DR);
		// Seed that differs from the reset value
		write_entry(INIT, WORD, 32'h1357_9BDF);
		random_entry(BYTE);
		random_entry(HALF);
		random_entry(WORD);
		// Restart while entries are queued
		write_entry(CR, WORD, 32'h0000_0001);
		read_literal(DR, 32'h1357_9BDF);
		repeat (2) random_entry(WORD);
		write_entry(INIT, WORD, 32'hA5A5_A5A5);
		read_model(DR);
		read_model(INIT);

		table_ready = 1'b1;
		for (int i = 0; i < steps.size(); i++)
		begin
			if (steps[i].rand_data)
				steps[i].data = $urandom();
		end

		m_crc  = 32'hFFFF_FFFF;
		m_init = 32'hFFFF_FFFF;
		m_poly = 32'h04C1_1DB7;
		m_idr  = 8'h00;
		m_cr   = 5'h00;

		repeat (3) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		cur_test = 0;
		for (int i = 0; i < steps.size(); i++)
		begin
			cur = steps[i];
			if (cur.test != cur_test)
			begin
				if (cur_test != 0)
					report_test(cur_test);
				cur_test    = cur.test;
				test_errors = 0;
			end
			if (cur.write)
			begin
				ahb_transfer(1'b1, cur.r, cur.size, cur.data, rdata);
				model_write(cur.r, cur.size, cur.data);
			end
			else
			begin
				expected = cur.use_model ? model_read(cur.r) : cur.expected;
				ahb_transfer(1'b0, cur.r, WORD, 32'h0, rdata);
				reads_checked++;
				if (rdata !== expected)
				begin
					$display("FAILED at %0t ns: step %0d read of %s returned %h, expected %h",
						$time, i, cur.r.name(), rdata, expected);
					errors++;
					test_errors++;
				end
			end
		end
		report_test(cur_test);

		$display("Summary: %0d tests passed, %0d tests failed, %0d reads checked, %0d errors",
			tests_passed, tests_failed, reads_checked, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- crc_ahb_top.sv
module crc_ahb_top
	import ahb_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSELx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	// Register strobes, configuration and status
	crc_cfg_if cfg ();

	// Buffer to FSM
	logic        pop;
	logic        empty;
	// Current entry
	logic [31:0] buf_data;
	hsize_t      buf_size;
	// FSM to counter and datapath
	logic        load;
	logic        step;
	logic        last;
	logic        op_load;
	logic        op_step;

	crc_host_interface u_host (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSELx     (HSELx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HREADY    (HREADY),
		.HWDATA    (HWDATA),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP),
		.cfg       (cfg.host)
	);

	crc_input_buffer u_buffer (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.cfg      (cfg.buffer),
		.pop      (pop),
		.empty    (empty),
		.data_out (buf_data),
		.size_out (buf_size)
	);

	crc_ctrl_fsm u_fsm (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.empty       (empty),
		.last        (last),
		.reset_chain (cfg.reset_chain),
		.pop         (pop),
		.load        (load),
		.step        (step),
		.op_load     (op_load),
		.op_step     (op_step),
		.engine_busy (cfg.engine_busy)
	);

	crc_byte_counter u_counter (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.load    (load),
		.size    (buf_size),
		.step    (step),
		.last    (last)
	);

	crc_datapath u_datapath (
		.HCLK    (HCLK),
		.HRESETn (HRESETn),
		.cfg     (cfg.engine),
		.data_in (buf_data),
		.size_in (buf_size),
		.op_load (op_load),
		.op_step (op_step)
	);

endmodule

//--- crc_datapath.sv
module crc_datapath
	import ahb_pkg::*, crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	crc_cfg_if.engine   cfg,
	input  logic [31:0] data_in,
	input  hsize_t      size_in,
	input  logic        op_load,
	input  logic        op_step
);

	logic [31:0] init_ff;
	logic [31:0] poly_ff;
	logic [7:0]  idr_ff;
	logic [31:0] crc_ff;
	// Data bytes still to fold, next byte on top
	logic [31:0] operand;
	logic [31:0] operand_next;
	logic [31:0] lane;
	logic [5:0]  xfer_w;
	logic [5:0]  rev_w;
	logic [5:0]  width;
	logic [31:0] width_mask;
	logic [31:0] crc_masked;

	// Reverse bits inside each w bit chunk, w a power of two
	function automatic logic [31:0] reverse_chunks(input logic [31:0] d, input logic [5:0] w);
		logic [31:0] r;
		int unsigned m;
		m = w - 1;
		for (int i = 0; i < 32; i++)
			r[i] = d[(i & ~m) | (m - (i & m))];
		return r;
	endfunction

	// Reverse the low w bits, clear the rest
	function automatic logic [31:0] reverse_low(input logic [31:0] c, input logic [5:0] w);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < 32; i++)
			if (i < w)
				r[i] = c[w - 1 - i];
		return r;
	endfunction

	// Fold one byte, MSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b,
		input logic [31:0] poly, input logic [31:0] mask, input logic [5:0] w);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int i = 7; i >= 0; i--)
		begin
			fb = r[w - 1] ^ b[i];
			r  = (r << 1) & mask;
			if (fb)
				r = r ^ (poly & mask);
		end
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Width and operand preparation

	always_comb
	begin
		case (cfg.poly_size)
			P32:     begin width = 6'd32; width_mask = 32'hFFFF_FFFF; end
			P16:     begin width = 6'd16; width_mask = 32'h0000_FFFF; end
			P8:      begin width = 6'd8;  width_mask = 32'h0000_00FF; end
			default: begin width = 6'd7;  width_mask = 32'h0000_007F; end
		endcase
	end

	always_comb
	begin
		case (size_in)
			BYTE:    begin xfer_w = 6'd8;  lane = {24'h0, data_in[7:0]}; end
			HALF:    begin xfer_w = 6'd16; lane = {16'h0, data_in[15:0]}; end
			default: begin xfer_w = 6'd32; lane = data_in; end
		endcase
		case (cfg.rev_in)
			REV_BYTE: rev_w = 6'd8;
			REV_HALF: rev_w = 6'd16;
			default:  rev_w = 6'd32;
		endcase
		// Chunk clamped to the transfer
		if (rev_w > xfer_w)
			rev_w = xfer_w;
		if (cfg.rev_in != REV_NONE)
			lane = reverse_chunks(lane, rev_w);
		// First byte of the transfer moves to the top
		operand_next = lane << (6'd32 - xfer_w);
	end

	//////////////////////////////////////////////////////////////////////
	// Registers

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_ff <= RESET_INIT;
			poly_ff <= RESET_POLY;
			idr_ff  <= 8'h00;
			crc_ff  <= RESET_INIT;
		end
		else
		begin
			if (cfg.crc_init_en)
				init_ff <= cfg.bus_wr;
			if (cfg.crc_poly_en)
				poly_ff <= cfg.bus_wr;
			if (cfg.crc_idr_en)
				idr_ff <= cfg.bus_wr[7:0];
			// Restart and INIT writes both seed the running CRC
			if (cfg.reset_chain)
				crc_ff <= init_ff;
			else if (cfg.crc_init_en)
				crc_ff <= cfg.bus_wr;
			else if (op_step)
				crc_ff <= crc_byte(crc_ff, operand[31:24], poly_ff, width_mask, width);
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (op_load)
			operand <= operand_next;
		else if (op_step)
			operand <= operand << 8;
	end

	// Result limited to the polynomial width
	assign crc_masked       = crc_ff & width_mask;
	assign cfg.crc_out      = cfg.rev_out ? reverse_low(crc_masked, width) : crc_masked;
	assign cfg.crc_init_out = init_ff;
	assign cfg.crc_poly_out = poly_ff;
	assign cfg.crc_idr_out  = idr_ff;

endmodule

//--- crc_byte_counter.sv
module crc_byte_counter
	import ahb_pkg::*;
(
	input  logic   HCLK,
	input  logic   HRESETn,
	input  logic   load,
	input  hsize_t size,
	input  logic   step,
	output logic   last
);

	logic [2:0] count;
	logic [2:0] load_count;

	// Bytes in a transfer
	always_comb
	begin
		case (size)
			BYTE:    load_count = 3'd1;
			HALF:    load_count = 3'd2;
			default: load_count = 3'd4;
		endcase
	end

	// Count only survives back to back steps so an aborted entry leaves nothing behind
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count <= '0;
		else if (load)
			count <= load_count;
		else if (step)
			count <= count - 1'b1;
		else
			count <= '0;
	end

	assign last = (count == 3'd1);

	// FSM reloads only after the previous entry ran out or was aborted
	a_load_when_done: assert property (@(posedge HCLK) disable iff (!HRESETn)
		load |-> (count == '0));

endmodule

//--- crc_ctrl_fsm.sv
module crc_ctrl_fsm
	import crc_pkg::*;
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic empty,
	input  logic last,
	input  logic reset_chain,
	output logic pop,
	output logic load,
	output logic step,
	output logic op_load,
	output logic op_step,
	output logic engine_busy
);

	fsm_state_t state;
	fsm_state_t state_next;

	// Next state
	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (!empty)
					state_next = ST_LOAD;
			ST_LOAD:
				state_next = ST_STEP;
			ST_STEP:
				if (last)
					state_next = empty ? ST_IDLE : ST_LOAD;
			default:
				state_next = ST_IDLE;
		endcase
		// Restart aborts whatever is in flight
		if (reset_chain)
			state_next = ST_IDLE;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	// An entry leaves the buffer on every entry into ST_LOAD
	assign pop = (state_next == ST_LOAD);

	// One load cycle, then one step per byte
	assign load    = (state == ST_LOAD) && !reset_chain;
	assign step    = (state == ST_STEP) && !reset_chain;
	assign op_load = load;
	assign op_step = step;

	// Busy also covers data still waiting in the buffer
	assign engine_busy = (state != ST_IDLE) || !empty;

	// Every step run starts after a load and steps back to back
	a_step_in_run: assert property (@(posedge HCLK) disable iff (!HRESETn)
		step |-> (state == ST_STEP) && ($past(load) || $past(step)));

endmodule

//--- crc_input_buffer.sv
module crc_input_buffer
	import ahb_pkg::*, crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	crc_cfg_if.buffer   cfg,
	input  logic        pop,
	output logic        empty,
	output logic [31:0] data_out,
	output hsize_t      size_out
);

	// Entry storage
	logic [31:0]          data_mem [BUF_DEPTH];
	hsize_t               size_mem [BUF_DEPTH];
	logic [BUF_PTR_W-1:0] wr_ptr;
	logic [BUF_PTR_W-1:0] rd_ptr;
	logic [BUF_CNT_W-1:0] count;
	logic                 push;

	function automatic logic [BUF_PTR_W-1:0] next_ptr(input logic [BUF_PTR_W-1:0] ptr);
		if (ptr == BUF_PTR_W'(BUF_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Host only strobes a push when there is room
	assign push            = cfg.buffer_write_en;
	assign empty           = (count == '0);
	assign cfg.buffer_full = (count == BUF_CNT_W'(BUF_DEPTH));

	// Pointers and fill level, flushed by a restart
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || cfg.reset_chain)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (push)
		begin
			data_mem[wr_ptr] <= cfg.bus_wr;
			size_mem[wr_ptr] <= cfg.bus_size;
		end
	end

	// Popped entry stays on the output while the engine works on it
	always_ff @(posedge HCLK)
	begin
		if (pop)
		begin
			data_out <= data_mem[rd_ptr];
			size_out <= size_mem[rd_ptr];
		end
	end

	// Host stalls keep pushes off a full buffer, the FSM keeps pops off an empty one
	a_no_overflow: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!(push && cfg.buffer_full) && !(pop && empty));

endmodule

//--- crc_host_interface.sv
module crc_host_interface
	import ahb_pkg::*, crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSELx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output hresp_t      HRESP,
	crc_cfg_if.host     cfg
);

	// Address phase copies held for the data phase
	logic       hselx_pp;
	htrans_t    htrans_pp;
	crc_reg_t   haddr_pp;
	hsize_t     hsize_pp;
	logic       hwrite_pp;

	// CR fields {rev_out, rev_in, poly_size}
	logic [4:0] cr_ff;

	logic       sample_bus;
	logic       write_en;
	logic       read_en;
	logic       dr_write;
	logic       dr_read;
	logic       init_write;
	logic       cr_en;

	//////////////////////////////////////////////////////////////////////
	// Address phase

	// Bus is taken only when the previous transfer completes
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= IDLE;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSELx;
			htrans_pp <= htrans_t'(HTRANS);
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= crc_reg_t'(HADDR[4:2]);
			hsize_pp  <= hsize_t'(HSIZE);
			hwrite_pp <= HWRITE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data phase decode

	// SEQ and BUSY are ignored so every access is a single NONSEQ
	assign write_en   = hselx_pp && (htrans_pp == NONSEQ) && hwrite_pp;
	assign read_en    = hselx_pp && (htrans_pp == NONSEQ) && !hwrite_pp;
	assign dr_write   = write_en && (haddr_pp == DR);
	assign dr_read    = read_en && (haddr_pp == DR);
	assign init_write = write_en && (haddr_pp == INIT);
	assign cr_en      = write_en && (haddr_pp == CR);

	// Stalled strobes fire in the cycle the wait condition clears
	assign cfg.buffer_write_en = dr_write && !cfg.buffer_full;
	assign cfg.crc_init_en     = init_write && !cfg.engine_busy;
	assign cfg.crc_idr_en      = write_en && (haddr_pp == IDR);
	assign cfg.crc_poly_en     = write_en && (haddr_pp == POL);
	assign cfg.reset_chain     = cr_en && HWDATA[0];

	// Write data comes straight from the data phase lanes
	assign cfg.bus_wr   = HWDATA;
	assign cfg.bus_size = hsize_pp;

	// Wait states
	assign HREADYOUT = !((dr_write && cfg.buffer_full) ||
	                     (dr_read && cfg.engine_busy) ||
	                     (init_write && cfg.engine_busy));

	assign HRESP = OKAY;

	// Control register bit 0 is a strobe and is not stored
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cr_ff <= RESET_CR;
		else if (cr_en)
			cr_ff <= HWDATA[7:3];
	end

	assign cfg.poly_size = poly_size_t'(cr_ff[1:0]);
	assign cfg.rev_in    = rev_in_t'(cr_ff[3:2]);
	assign cfg.rev_out   = cr_ff[4];

	// Read mux on the registered offset
	always_comb
	begin
		case (haddr_pp)
			DR:      HRDATA = cfg.crc_out;
			IDR:     HRDATA = {24'h0, cfg.crc_idr_out};
			CR:      HRDATA = {24'h0, cr_ff, 3'b000};
			INIT:    HRDATA = cfg.crc_init_out;
			POL:     HRDATA = cfg.crc_poly_out;
			default: HRDATA = 32'h0;
		endcase
	end

	// A wait state only ever waits on work still held by the core
	a_wait_on_busy_core: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!HREADYOUT |-> cfg.engine_busy);

	// Non stalling strobes come from a write sampled one clock earlier
	a_enable_from_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(cfg.crc_idr_en || cfg.crc_poly_en || cr_en) |-> $past(sample_bus && HSELx && HWRITE));

endmodule

//--- crc_cfg_if.sv
interface crc_cfg_if
	import ahb_pkg::*, crc_pkg::*;
();

	// Strobes and configuration from the host side
	logic        buffer_write_en;
	logic        crc_init_en;
	logic        crc_poly_en;
	logic        crc_idr_en;
	logic        reset_chain;
	logic [31:0] bus_wr;
	hsize_t      bus_size;
	poly_size_t  poly_size;
	rev_in_t     rev_in;
	logic        rev_out;

	// Status and read back values from the core
	logic        buffer_full;
	logic        engine_busy;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;

	modport host (
		output buffer_write_en, crc_init_en, crc_poly_en, crc_idr_en, reset_chain,
		output bus_wr, bus_size, poly_size, rev_in, rev_out,
		input  buffer_full, engine_busy, crc_out, crc_init_out, crc_poly_out, crc_idr_out
	);

	modport buffer (
		input  buffer_write_en, bus_wr, bus_size, reset_chain,
		output buffer_full
	);

	modport engine (
		input  crc_init_en, crc_poly_en, crc_idr_en, reset_chain,
		input  bus_wr, poly_size, rev_in, rev_out,
		output crc_out, crc_init_out, crc_poly_out, crc_idr_out
	);

endinterface

//--- crc_pkg.sv
package crc_pkg;

	// Word offsets taken from HADDR[4:2]
	typedef enum logic [2:0]
	{
		DR   = 3'h0,
		IDR  = 3'h1,
		CR   = 3'h2,
		INIT = 3'h4,
		POL  = 3'h5
	} crc_reg_t;

	// CR[4:3] polynomial width
	typedef enum logic [1:0] {P32, P16, P8, P7} poly_size_t;

	// CR[6:5] input bit reversal chunk
	typedef enum logic [1:0] {REV_NONE, REV_BYTE, REV_HALF, REV_WORD} rev_in_t;

	// Control sequencer states
	typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_STEP} fsm_state_t;

	// Reset values
	localparam logic [31:0] RESET_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_POLY = 32'h04C1_1DB7;
	// CR fields {rev_out, rev_in, poly_size}
	localparam logic [4:0]  RESET_CR   = 5'h00;

	// Input buffer geometry
	localparam int BUF_DEPTH = 2;
	localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
	localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

endpackage

//--- ahb_pkg.sv
package ahb_pkg;

	// Transfer type on HTRANS
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Slave response on HRESP
	typedef enum logic
	{
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_t;

	// Transfer size on HSIZE, only the sizes this slave accepts
	typedef enum logic [2:0]
	{
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_t;

endpackage
